// ==== Bender.yml ====
package:
  name: backend

sources:
  - hw/backend_pkg.sv
  - hw/exec_if.sv
  - hw/instr_dispatch.sv
  - hw/alu_unit.sv
  - hw/mul_unit.sv
  - hw/reorder_buffer.sv
  - hw/backend_top.sv
  - target: test
    files:
      - tb/tb_clock_gen.sv
      - tb/backend_tb.sv

// ==== backend.f ====
hw/backend_pkg.sv
hw/exec_if.sv
hw/instr_dispatch.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/backend_top.sv
tb/tb_clock_gen.sv
tb/backend_tb.sv

// ==== hw/alu_unit.sv ====
`timescale 1ns/10ps

module alu_unit (
	input logic   CLK,
	input logic   i_reset,
	exec_if.unit  ch
);
	import backend_pkg::*;

	xlen_t    alu_res;
	logic     slt;
	logic     wb_vld_q;
	rob_tag_t wb_tag_q;
	xlen_t    wb_data_q;

	assign slt = $signed(ch.req_a) < $signed(ch.req_b);

	always_comb begin
		case (ch.req_op)
			OP_ADD:  alu_res = ch.req_a + ch.req_b;
			OP_SUB:  alu_res = ch.req_a - ch.req_b;
			OP_AND:  alu_res = ch.req_a & ch.req_b;
			OP_OR:   alu_res = ch.req_a | ch.req_b;
			OP_XOR:  alu_res = ch.req_a ^ ch.req_b;
			OP_SLT:  alu_res = {{(XLEN-1){1'b0}}, slt};
			// Multiplies never reach this unit
			default: alu_res = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			wb_vld_q <= 1'b0;
		end else begin
			wb_vld_q <= ch.req_valid;
		end
	end

	// Result and tag held for one writeback cycle
	always_ff @(posedge CLK) begin
		if (ch.req_valid) begin
			wb_tag_q <= ch.req_tag;
			wb_data_q <= alu_res;
		end
	end

	assign ch.wb_valid = wb_vld_q;
	assign ch.wb_tag = wb_tag_q;
	assign ch.wb_data = wb_data_q;

endmodule

// ==== hw/backend_pkg.sv ====
package backend_pkg;

	// Datapath and buffer sizing
	localparam int XLEN = 64;
	localparam int ROB_DEPTH = 8;
	localparam int MUL_STAGES = 3;
	localparam int TAG_W = $clog2(ROB_DEPTH);

	// Operand and result word
	typedef logic [XLEN-1:0] xlen_t;

	// Architectural destination index
	typedef logic [4:0] reg_idx_t;

	// Reorder slot index
	typedef logic [TAG_W-1:0] rob_tag_t;

	// Occupancy count, one bit wider so a full buffer is representable
	typedef logic [TAG_W:0] rob_cnt_t;

	// Micro-op opcodes
	// SLT is a signed compare, MULH returns the upper half of the signed product
	typedef enum logic [2:0] {
		OP_ADD  = 3'd0,
		OP_SUB  = 3'd1,
		OP_AND  = 3'd2,
		OP_OR   = 3'd3,
		OP_XOR  = 3'd4,
		OP_SLT  = 3'd5,
		OP_MUL  = 3'd6,
		OP_MULH = 3'd7
	} op_e;

endpackage

// ==== hw/backend_top.sv ====
`timescale 1ns/10ps

module backend_top (
	input  logic                  CLK,
	input  logic                  i_reset,
	input  logic                  i_uop_valid,
	output logic                  o_uop_ready,
	input  backend_pkg::op_e      i_uop_op,
	input  backend_pkg::reg_idx_t i_uop_rd,
	input  backend_pkg::xlen_t    i_uop_a,
	input  backend_pkg::xlen_t    i_uop_b,
	output logic                  o_commit_valid,
	input  logic                  i_commit_ready,
	output backend_pkg::reg_idx_t o_commit_rd,
	output backend_pkg::xlen_t    o_commit_data
);
	import backend_pkg::*;

	logic     rob_free;
	rob_tag_t rob_tag;
	logic     alloc_valid;
	reg_idx_t alloc_rd;

	// One channel per execution unit
	exec_if alu_ch ();
	exec_if mul_ch ();

	instr_dispatch instr_dispatch_inst (
		.CLK           (CLK),
		.i_reset       (i_reset),
		.i_uop_valid   (i_uop_valid),
		.o_uop_ready   (o_uop_ready),
		.i_uop_op      (i_uop_op),
		.i_uop_rd      (i_uop_rd),
		.i_uop_a       (i_uop_a),
		.i_uop_b       (i_uop_b),
		.i_rob_free    (rob_free),
		.i_rob_tag     (rob_tag),
		.o_alloc_valid (alloc_valid),
		.o_alloc_rd    (alloc_rd),
		.alu_ch        (alu_ch.issuer),
		.mul_ch        (mul_ch.issuer)
	);

	alu_unit alu_unit_inst (
		.CLK     (CLK),
		.i_reset (i_reset),
		.ch      (alu_ch.unit)
	);

	mul_unit mul_unit_inst (
		.CLK     (CLK),
		.i_reset (i_reset),
		.ch      (mul_ch.unit)
	);

	reorder_buffer reorder_buffer_inst (
		.CLK            (CLK),
		.i_reset        (i_reset),
		.i_alloc_valid  (alloc_valid),
		.i_alloc_rd     (alloc_rd),
		.o_rob_free     (rob_free),
		.o_rob_tag      (rob_tag),
		.alu_wb         (alu_ch.collector),
		.mul_wb         (mul_ch.collector),
		.o_commit_valid (o_commit_valid),
		.i_commit_ready (i_commit_ready),
		.o_commit_rd    (o_commit_rd),
		.o_commit_data  (o_commit_data)
	);

endmodule

// ==== hw/exec_if.sv ====
`timescale 1ns/10ps

interface exec_if;
	import backend_pkg::*;

	// Issue request into an execution unit
	logic     req_valid;
	rob_tag_t req_tag;
	op_e      req_op;
	xlen_t    req_a;
	xlen_t    req_b;

	// Writeback toward the reorder buffer
	logic     wb_valid;
	rob_tag_t wb_tag;
	xlen_t    wb_data;

	modport issuer (
		output req_valid, req_tag, req_op, req_a, req_b
	);

	modport unit (
		input  req_valid, req_tag, req_op, req_a, req_b,
		output wb_valid, wb_tag, wb_data
	);

	modport collector (
		input wb_valid, wb_tag, wb_data
	);

endinterface

// ==== hw/instr_dispatch.sv ====
`timescale 1ns/10ps

module instr_dispatch (
	input  logic                  CLK,
	input  logic                  i_reset,
	input  logic                  i_uop_valid,
	output logic                  o_uop_ready,
	input  backend_pkg::op_e      i_uop_op,
	input  backend_pkg::reg_idx_t i_uop_rd,
	input  backend_pkg::xlen_t    i_uop_a,
	input  backend_pkg::xlen_t    i_uop_b,
	input  logic                  i_rob_free,
	input  backend_pkg::rob_tag_t i_rob_tag,
	output logic                  o_alloc_valid,
	output backend_pkg::reg_idx_t o_alloc_rd,
	exec_if.issuer                alu_ch,
	exec_if.issuer                mul_ch
);
	import backend_pkg::*;

	logic     uop_fire;
	logic     to_mul;
	logic     alu_vld_q;
	logic     mul_vld_q;
	rob_tag_t tag_q;
	op_e      op_q;
	xlen_t    a_q;
	xlen_t    b_q;

	// A free reorder slot is the only thing that can hold up the input
	assign o_uop_ready = i_rob_free;
	assign uop_fire = i_uop_valid && i_rob_free;

	// Tail slot is claimed in the same cycle the micro-op is taken
	assign o_alloc_valid = uop_fire;
	assign o_alloc_rd = i_uop_rd;

	assign to_mul = (i_uop_op == OP_MUL) || (i_uop_op == OP_MULH);

	always_ff @(posedge CLK) begin
		if (i_reset) begin
			alu_vld_q <= 1'b0;
			mul_vld_q <= 1'b0;
		end else begin
			alu_vld_q <= uop_fire && !to_mul;
			mul_vld_q <= uop_fire && to_mul;
		end
	end

	// Issue payload is shared, only the valids pick the unit
	always_ff @(posedge CLK) begin
		if (uop_fire) begin
			tag_q <= i_rob_tag;
			op_q <= i_uop_op;
			a_q <= i_uop_a;
			b_q <= i_uop_b;
		end
	end

	assign alu_ch.req_valid = alu_vld_q;
	assign alu_ch.req_tag = tag_q;
	assign alu_ch.req_op = op_q;
	assign alu_ch.req_a = a_q;
	assign alu_ch.req_b = b_q;

	assign mul_ch.req_valid = mul_vld_q;
	assign mul_ch.req_tag = tag_q;
	assign mul_ch.req_op = op_q;
	assign mul_ch.req_a = a_q;
	assign mul_ch.req_b = b_q;

endmodule

// ==== hw/mul_unit.sv ====
`timescale 1ns/10ps

module mul_unit (
	input logic   CLK,
	input logic   i_reset,
	exec_if.unit  ch
);
	import backend_pkg::*;

	logic [MUL_STAGES-1:0]    vld_q;
	rob_tag_t                 tag_q [MUL_STAGES];
	logic [MUL_STAGES-2:0]    hi_q;
	xlen_t                    op_a_q;
	xlen_t                    op_b_q;
	logic signed [2*XLEN-1:0] prod_q;
	xlen_t                    res_q;

	// Valid shifts through every stage, a new request may enter each cycle
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			vld_q <= '0;
		end else begin
			vld_q <= {vld_q[MUL_STAGES-2:0], ch.req_valid};
		end
	end

	// Tag and half select follow their operands
	always_ff @(posedge CLK) begin
		tag_q[0] <= ch.req_tag;
		hi_q[0] <= (ch.req_op == OP_MULH);
		for (int i = 1; i < MUL_STAGES; i++) begin
			tag_q[i] <= tag_q[i-1];
		end
		for (int i = 1; i < MUL_STAGES - 1; i++) begin
			hi_q[i] <= hi_q[i-1];
		end
	end

	// Stage 1 captures operands
	always_ff @(posedge CLK) begin
		op_a_q <= ch.req_a;
		op_b_q <= ch.req_b;
	end

	// Stage 2 full signed product, both sides sign extended to 128 bits
	always_ff @(posedge CLK) begin
		prod_q <= $signed(op_a_q) * $signed(op_b_q);
	end

	// Stage 3 picks upper or lower half
	always_ff @(posedge CLK) begin
		res_q <= hi_q[MUL_STAGES-2] ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
	end

	assign ch.wb_valid = vld_q[MUL_STAGES-1];
	assign ch.wb_tag = tag_q[MUL_STAGES-1];
	assign ch.wb_data = res_q;

endmodule

// ==== hw/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer (
	input  logic                  CLK,
	input  logic                  i_reset,
	input  logic                  i_alloc_valid,
	input  backend_pkg::reg_idx_t i_alloc_rd,
	output logic                  o_rob_free,
	output backend_pkg::rob_tag_t o_rob_tag,
	exec_if.collector             alu_wb,
	exec_if.collector             mul_wb,
	output logic                  o_commit_valid,
	input  logic                  i_commit_ready,
	output backend_pkg::reg_idx_t o_commit_rd,
	output backend_pkg::xlen_t    o_commit_data
);
	import backend_pkg::*;

	rob_tag_t             head_q;
	rob_tag_t             tail_q;
	rob_cnt_t             count_q;
	logic [ROB_DEPTH-1:0] done_q;
	reg_idx_t             rd_q [ROB_DEPTH];
	xlen_t                data_q [ROB_DEPTH];
	logic                 commit_fire;

	assign o_rob_free = (count_q != rob_cnt_t'(ROB_DEPTH));
	assign o_rob_tag = tail_q;

	// Head retires only once its own result is in, younger ones wait
	assign o_commit_valid = (count_q != '0) && done_q[head_q];
	assign o_commit_rd = rd_q[head_q];
	assign o_commit_data = data_q[head_q];
	assign commit_fire = o_commit_valid && i_commit_ready;

	// Pointers wrap naturally at the power-of-two depth
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			head_q <= '0;
			tail_q <= '0;
			count_q <= '0;
		end else begin
			if (i_alloc_valid) begin
				tail_q <= tail_q + 1'b1;
			end
			if (commit_fire) begin
				head_q <= head_q + 1'b1;
			end
			case ({i_alloc_valid, commit_fire})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// Done flags, set by either unit and cleared as the head retires
	always_ff @(posedge CLK) begin
		if (i_reset) begin
			done_q <= '0;
		end else begin
			if (commit_fire) begin
				done_q[head_q] <= 1'b0;
			end
			if (alu_wb.wb_valid) begin
				done_q[alu_wb.wb_tag] <= 1'b1;
			end
			if (mul_wb.wb_valid) begin
				done_q[mul_wb.wb_tag] <= 1'b1;
			end
		end
	end

	// Both units may write back in the same cycle, always to different slots
	always_ff @(posedge CLK) begin
		if (i_alloc_valid) begin
			rd_q[tail_q] <= i_alloc_rd;
		end
		if (alu_wb.wb_valid) begin
			data_q[alu_wb.wb_tag] <= alu_wb.wb_data;
		end
		if (mul_wb.wb_valid) begin
			data_q[mul_wb.wb_tag] <= mul_wb.wb_data;
		end
	end

endmodule

// ==== tb/backend_tb.sv ====
`timescale 1ns/10ps

module backend_tb;
	import backend_pkg::*;

	localparam int NUM_VECS = 16;
	localparam int NUM_PASSES = 2;
	localparam int CLK_PERIOD_NS = 20;
	localparam int WATCHDOG_NS = NUM_VECS * 40 * CLK_PERIOD_NS;
	localparam int SEED = 385;

	typedef struct packed {
		op_e      op;
		reg_idx_t rd;
		xlen_t    a;
		xlen_t    b;
		xlen_t    exp;
	} vec_t;

	typedef enum {COMMIT_HOLD, COMMIT_ALWAYS, COMMIT_RANDOM} commit_mode_e;

	// Expected values worked out by hand from the opcode rules
	vec_t tbl [NUM_VECS] = '{
		'{OP_ADD,  5'd1,  64'd5, 64'd7, 64'd12},
		'{OP_SUB,  5'd2,  64'd3, 64'd10, 64'hFFFF_FFFF_FFFF_FFF9},
		'{OP_AND,  5'd3,  64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00,
			64'hF000_F000_F000_F000},
		'{OP_OR,   5'd4,  64'h0000_0000_FFFF_0000, 64'h1234_0000_0000_5678,
			64'h1234_0000_FFFF_5678},
		'{OP_XOR,  5'd5,  64'hAAAA_AAAA_AAAA_AAAA, 64'hFFFF_FFFF_FFFF_FFFF,
			64'h5555_5555_5555_5555},
		'{OP_SLT,  5'd6,  64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 64'd1},
		'{OP_SLT,  5'd7,  64'd1, 64'hFFFF_FFFF_FFFF_FFFF, 64'd0},
		'{OP_SLT,  5'd8,  64'hFFFF_FFFF_FFFF_FFFB, 64'hFFFF_FFFF_FFFF_FFFD, 64'd1},
		'{OP_MUL,  5'd9,  64'hFFFF_FFFF_FFFF_FFFD, 64'd7, 64'hFFFF_FFFF_FFFF_FFEB},
		'{OP_MULH, 5'd10, 64'hFFFF_FFFF_FFFF_FFFD, 64'd7, 64'hFFFF_FFFF_FFFF_FFFF},
		'{OP_MULH, 5'd11, 64'h4000_0000_0000_0000, 64'd4, 64'd1},
		// Multiply with three ALU ops right behind it
		'{OP_MUL,  5'd12, 64'h0000_0001_0000_0000, 64'h0000_0001_0000_0000, 64'd0},
		'{OP_ADD,  5'd13, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 64'h8000_0000_0000_0000},
		'{OP_SUB,  5'd14, 64'd0, 64'd1, 64'hFFFF_FFFF_FFFF_FFFF},
		'{OP_XOR,  5'd15, 64'h0123_4567_89AB_CDEF, 64'h0123_4567_89AB_CDEF, 64'd0},
		'{OP_MULH, 5'd16, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
			64'h4000_0000_0000_0000}
	};

	logic         clk;
	logic         rst;
	logic         uop_valid;
	logic         uop_ready;
	op_e          uop_op;
	reg_idx_t     uop_rd;
	xlen_t        uop_a;
	xlen_t        uop_b;
	logic         commit_valid;
	logic         commit_ready;
	reg_idx_t     commit_rd;
	xlen_t        commit_data;
	commit_mode_e commit_mode;
	int           commit_cnt;
	int           pass_cnt;
	int           fail_cnt;
	int           err_cnt;

	tb_clock_gen clock_gen_inst (
		.o_clk   (clk),
		.o_reset (rst)
	);

	backend_top backend_top_inst (
		.CLK            (clk),
		.i_reset        (rst),
		.i_uop_valid    (uop_valid),
		.o_uop_ready    (uop_ready),
		.i_uop_op       (uop_op),
		.i_uop_rd       (uop_rd),
		.i_uop_a        (uop_a),
		.i_uop_b        (uop_b),
		.o_commit_valid (commit_valid),
		.i_commit_ready (commit_ready),
		.o_commit_rd    (commit_rd),
		.o_commit_data  (commit_data)
	);

	task automatic check_data(input string name, input xlen_t exp, input xlen_t act,
			inout bit ok);
		if (act !== exp) begin
			$display("Error %s data expected %h actual %h", name, exp, act);
			ok = 1'b0;
		end
	endtask

	task automatic check_rd(input string name, input reg_idx_t exp, input reg_idx_t act,
			inout bit ok);
		if (act !== exp) begin
			$display("Error %s rd expected %0d actual %0d", name, exp, act);
			ok = 1'b0;
		end
	endtask

	// Offers table entries one per cycle
	// Ready sampled at the negedge still holds at the transfer edge
	task automatic feed_uops(input int first, input bit stop_when_full, output int next_idx);
		int  idx;
		bit  stalled;
		idx = first;
		stalled = 1'b0;
		while (idx < NUM_VECS && !stalled) begin
			@(posedge clk);
			uop_valid <= 1'b1;
			uop_op <= tbl[idx].op;
			uop_rd <= tbl[idx].rd;
			uop_a <= tbl[idx].a;
			uop_b <= tbl[idx].b;
			@(negedge clk);
			if (uop_ready) begin
				idx++;
			end else if (stop_when_full) begin
				stalled = 1'b1;
			end
		end
		@(posedge clk);
		uop_valid <= 1'b0;
		next_idx = idx;
	endtask

	task automatic end_run();
		$display("Tests %0d, passed %0d, failed %0d, other errors %0d",
			commit_cnt, pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0 && commit_cnt == NUM_PASSES * NUM_VECS) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	// Commit ready follows the current phase
	initial begin : commit_driver
		void'($urandom(SEED));
		forever begin
			@(posedge clk);
			case (commit_mode)
				COMMIT_ALWAYS: commit_ready <= 1'b1;
				COMMIT_RANDOM: commit_ready <= 1'($urandom % 2);
				default:       commit_ready <= 1'b0;
			endcase
		end
	end

	// Commits are checked in order against the table once per pass
	always @(negedge clk) begin : commit_monitor
		int    idx;
		string name;
		bit    ok;
		if (!rst && commit_valid && commit_ready) begin
			if (commit_cnt >= NUM_PASSES * NUM_VECS) begin
				$display("An extra commit appeared after the whole table had retired");
				err_cnt++;
			end else begin
				idx = commit_cnt % NUM_VECS;
				name = $sformatf("p%0d_v%0d_%s", commit_cnt / NUM_VECS, idx,
					tbl[idx].op.name());
				ok = 1'b1;
				check_rd(name, tbl[idx].rd, commit_rd, ok);
				check_data(name, tbl[idx].exp, commit_data, ok);
				if (ok) begin
					pass_cnt++;
					$display("Test %s correct", name);
				end else begin
					fail_cnt++;
				end
			end
			commit_cnt++;
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns with %0d of %0d commits seen",
			WATCHDOG_NS, commit_cnt, NUM_PASSES * NUM_VECS);
		err_cnt++;
		end_run();
	end

	initial begin : main
		int next_idx;
		uop_valid = 1'b0;
		uop_op = OP_ADD;
		uop_rd = '0;
		uop_a = '0;
		uop_b = '0;
		commit_ready = 1'b0;
		commit_mode = COMMIT_HOLD;
		commit_cnt = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		err_cnt = 0;
		wait (!rst);

		// Idle after reset
		repeat (4) begin
			@(negedge clk);
			if (commit_valid || !uop_ready) begin
				$display("After reset the DUT was not idle with commit valid or not ready");
				err_cnt++;
			end
		end

		// First pass drains freely so ops issue back to back
		commit_mode = COMMIT_ALWAYS;
		feed_uops(0, 1'b0, next_idx);
		wait (commit_cnt == NUM_VECS);
		@(negedge clk);
		commit_mode = COMMIT_HOLD;
		repeat (2) @(negedge clk);

		// Second pass fills the buffer before commit opens
		feed_uops(0, 1'b1, next_idx);
		if (next_idx != ROB_DEPTH) begin
			$display("Error hold_full accepted count expected %0d actual %0d",
				ROB_DEPTH, next_idx);
			err_cnt++;
		end
		repeat (4) @(negedge clk);
		commit_mode = COMMIT_RANDOM;
		feed_uops(next_idx, 1'b0, next_idx);
		wait (commit_cnt == NUM_PASSES * NUM_VECS);
		repeat (4) @(posedge clk);
		end_run();
	end

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic o_clk,
	output logic o_reset
);
	localparam int HALF_PERIOD_NS = 10;

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
	end

	// Reset held across the first two rising edges
	initial begin
		o_reset = 1'b1;
		repeat (2) @(posedge o_clk);
		o_reset <= 1'b0;
	end

endmodule
